// ==== dv/dot2_checker.sv ====
`timescale 1ns/1ps

module dot2_checker #(
    parameter int M = 8,
    parameter int N = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [apb_regs_pkg::ADDR_W-1:0] paddr,
    input  logic [31:0]                     pwdata,
    input  logic [31:0]                     prdata,
    input  logic                            pready,
    output int                              error_count,
    output int                              check_count
);

    localparam logic [31:0] STAT_BUSY = 32'd1 << apb_regs_pkg::STAT_BUSY_BIT;
    localparam logic [31:0] STAT_DONE = 32'd1 << apb_regs_pkg::STAT_DONE_BIT;

    logic [31:0] a0_m;
    logic [31:0] b0_m;
    logic [31:0] a1_m;
    logic [31:0] b1_m;
    logic [31:0] exp_result;
    logic [31:0] pending_sum;
    logic        model_busy;
    logic        model_done;

    function automatic logic [31:0] keep_bits(input logic [31:0] value, input int width);
        return value & ((32'd1 << width) - 32'd1);
    endfunction

    function automatic string reg_name(input logic [apb_regs_pkg::ADDR_W-1:0] addr);
        case (addr)
            apb_regs_pkg::REG_A0:     reg_name = "A0";
            apb_regs_pkg::REG_B0:     reg_name = "B0";
            apb_regs_pkg::REG_A1:     reg_name = "A1";
            apb_regs_pkg::REG_B1:     reg_name = "B1";
            apb_regs_pkg::REG_CTRL:   reg_name = "CTRL";
            apb_regs_pkg::REG_RESULT: reg_name = "RESULT";
            default:                  reg_name = "unmapped";
        endcase
    endfunction

    function automatic logic [31:0] expected_read(input logic [apb_regs_pkg::ADDR_W-1:0] addr);
        case (addr)
            apb_regs_pkg::REG_A0:     expected_read = a0_m;
            apb_regs_pkg::REG_B0:     expected_read = b0_m;
            apb_regs_pkg::REG_A1:     expected_read = a1_m;
            apb_regs_pkg::REG_B1:     expected_read = b1_m;
            apb_regs_pkg::REG_RESULT: expected_read = exp_result;
            default:                  expected_read = '0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input string expected);
        error_count++;
        $display("FAIL t=%0t prdata(%s) expected %s actual 0x%08h", $time, name, expected, prdata);
    endtask

    // The slave never inserts wait states, so every access cycle must see pready high.
    task automatic check_ready();
        check_count++;
        if (pready !== 1'b1) begin
            error_count++;
            $display("FAIL t=%0t pready expected 1 actual %b", $time, pready);
        end
    endtask

    task automatic check_status();
        check_count++;
        // While a run is in flight both busy and a finished run are legal.
        if (model_busy) begin
            if (prdata === STAT_DONE) begin
                model_busy = 1'b0;
                model_done = 1'b1;
                exp_result = pending_sum;
            end else if (prdata !== STAT_BUSY) begin
                report_mismatch("STATUS", $sformatf("0x%08h or 0x%08h", STAT_BUSY, STAT_DONE));
            end
        end else if (prdata !== (model_done ? STAT_DONE : 32'd0)) begin
            report_mismatch("STATUS", $sformatf("0x%08h", model_done ? STAT_DONE : 32'd0));
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            a0_m        = '0;
            b0_m        = '0;
            a1_m        = '0;
            b1_m        = '0;
            exp_result  = '0;
            pending_sum = '0;
            model_busy  = 1'b0;
            model_done  = 1'b0;
            error_count = 0;
            check_count = 0;
        end else if (psel && penable && pwrite) begin
            check_ready();
            case (paddr)
                apb_regs_pkg::REG_A0: a0_m = keep_bits(pwdata, M);
                apb_regs_pkg::REG_B0: b0_m = keep_bits(pwdata, N);
                apb_regs_pkg::REG_A1: a1_m = keep_bits(pwdata, M);
                apb_regs_pkg::REG_B1: b1_m = keep_bits(pwdata, N);
                apb_regs_pkg::REG_CTRL: begin
                    if (pwdata[apb_regs_pkg::CTRL_START_BIT] && !model_busy) begin
                        pending_sum = a0_m * b0_m + a1_m * b1_m;
                        model_busy  = 1'b1;
                        model_done  = 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end else if (psel && penable) begin
            check_ready();
            if (paddr == apb_regs_pkg::REG_STATUS) begin
                check_status();
            end else begin
                check_count++;
                if (prdata !== expected_read(paddr))
                    report_mismatch(reg_name(paddr), $sformatf("0x%08h", expected_read(paddr)));
            end
        end
    end

endmodule

// ==== dv/tb_dot2.sv ====
`timescale 1ns/1ps

module tb_dot2;

    localparam int M         = mul_pkg::OP_W_DEFAULT;
    localparam int N         = mul_pkg::OP_W_DEFAULT;
    localparam int MAX_POLLS = 200;
    localparam int NUM_RAND  = 200;

    logic                            clk;
    logic                            rst;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [apb_regs_pkg::ADDR_W-1:0] paddr;
    logic [31:0]                     pwdata;
    logic [31:0]                     prdata;
    logic                            pready;
    int                              error_count;
    int                              check_count;
    int                              timeout_count;
    logic                            timed_out;

    dot2_mul_top #(.M(M), .N(N)) DUT (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    dot2_checker #(.M(M), .N(N)) u_checker (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .error_count(error_count), .check_count(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // After a timeout the bus goes quiet so the run drops straight to its summary.
    task automatic apb_write(input logic [apb_regs_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
        if (timed_out)
            return;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [apb_regs_pkg::ADDR_W-1:0] addr, output logic [31:0] data);
        data = '0;
        if (timed_out)
            return;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[apb_regs_pkg::STAT_DONE_BIT] && polls < MAX_POLLS && !timed_out) begin
            apb_read(apb_regs_pkg::REG_STATUS, status);
            polls++;
        end
        if (!status[apb_regs_pkg::STAT_DONE_BIT] && !timed_out) begin
            $display("Timeout: STATUS never showed done within %0d polls at t=%0t", MAX_POLLS, $time);
            timeout_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic write_operands(input logic [31:0] a0, input logic [31:0] b0,
                                  input logic [31:0] a1, input logic [31:0] b1);
        apb_write(apb_regs_pkg::REG_A0, a0);
        apb_write(apb_regs_pkg::REG_B0, b0);
        apb_write(apb_regs_pkg::REG_A1, a1);
        apb_write(apb_regs_pkg::REG_B1, b1);
    endtask

    task automatic run_dot(input logic [31:0] a0, input logic [31:0] b0,
                           input logic [31:0] a1, input logic [31:0] b1);
        logic [31:0] rd;
        write_operands(a0, b0, a1, b1);
        apb_write(apb_regs_pkg::REG_CTRL, 32'd1 << apb_regs_pkg::CTRL_START_BIT);
        wait_done();
        apb_read(apb_regs_pkg::REG_RESULT, rd);
    endtask

    initial begin
        logic [31:0] rd;
        int          i;
        rst           = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        timeout_count = 0;
        timed_out     = 1'b0;
        void'($urandom(32'h353a430d));
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        apb_read(apb_regs_pkg::REG_STATUS, rd);
        apb_read(apb_regs_pkg::REG_RESULT, rd);
        apb_read(apb_regs_pkg::REG_A0, rd);
        apb_read(apb_regs_pkg::REG_B0, rd);
        apb_read(apb_regs_pkg::REG_A1, rd);
        apb_read(apb_regs_pkg::REG_B1, rd);

        // Different counts of ones in b make the lanes finish in either order.
        run_dot(32'h0, 32'h0, 32'h0, 32'h0);
        run_dot(32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        run_dot(32'h0, 32'hFF, 32'hFF, 32'h0);
        run_dot(32'hFF, 32'h01, 32'hFF, 32'hFF);
        run_dot(32'hFF, 32'hFF, 32'hFF, 32'h80);
        run_dot(32'hA5, 32'h08, 32'h5A, 32'h40);

        for (i = 0; i < NUM_RAND; i++)
            run_dot($urandom(), $urandom(), $urandom(), $urandom());

        // A0 changes between the two starts, so an accepted second start would alter RESULT.
        write_operands(32'h37, 32'hC3, 32'h9E, 32'h5B);
        apb_write(apb_regs_pkg::REG_CTRL, 32'h1);
        apb_write(apb_regs_pkg::REG_A0, 32'hC8);
        apb_write(apb_regs_pkg::REG_CTRL, 32'h1);
        wait_done();
        apb_read(apb_regs_pkg::REG_RESULT, rd);
        repeat (3) apb_read(apb_regs_pkg::REG_STATUS, rd);

        write_operands(32'h12, 32'h34, 32'h56, 32'h78);
        apb_write(apb_regs_pkg::REG_CTRL, 32'h1);
        write_operands(32'hE1, 32'hF7, 32'h2C, 32'hB9);
        apb_read(apb_regs_pkg::REG_A0, rd);
        apb_read(apb_regs_pkg::REG_B0, rd);
        apb_read(apb_regs_pkg::REG_A1, rd);
        apb_read(apb_regs_pkg::REG_B1, rd);
        wait_done();
        apb_read(apb_regs_pkg::REG_RESULT, rd);
        apb_write(apb_regs_pkg::REG_CTRL, 32'h1);
        wait_done();
        apb_read(apb_regs_pkg::REG_RESULT, rd);

        apb_write(apb_regs_pkg::REG_A0, 32'hFFFF_FF5A);
        apb_write(apb_regs_pkg::REG_B1, 32'h1234_5601);
        apb_read(apb_regs_pkg::REG_A0, rd);
        apb_read(apb_regs_pkg::REG_B1, rd);
        apb_write(8'h1C, 32'hDEAD_BEEF);
        apb_read(8'h1C, rd);
        apb_read(8'h20, rd);
        apb_read(8'hFC, rd);
        apb_read(8'h02, rd);
        apb_read(apb_regs_pkg::REG_CTRL, rd);

        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the dot product testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -Wno-fatal -f verilog.f --top-module tb_dot2 -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_dot2)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi

// ==== verilog.f ====
verilog/mul_pkg.sv
verilog/apb_regs_pkg.sv
verilog/shift_add_ctrl.sv
verilog/shift_add_lane.sv
verilog/dot_combiner.sv
verilog/apb_dot_regs.sv
verilog/dot2_mul_top.sv
dv/dot2_checker.sv
dv/tb_dot2.sv

// ==== verilog/apb_dot_regs.sv ====
`timescale 1ns/1ps

module apb_dot_regs #(
    parameter int M = 8,
    parameter int N = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [apb_regs_pkg::ADDR_W-1:0] paddr,
    input  logic [31:0]                     pwdata,
    input  logic                            busy,
    input  logic                            done,
    input  logic [M+N:0]                    sum,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic [M-1:0]                    a0,
    output logic [M-1:0]                    a1,
    output logic [N-1:0]                    b0,
    output logic [N-1:0]                    b1,
    output logic                            start
);

    logic wr_en;

    // No wait states are ever inserted.
    assign pready = 1'b1;

    assign wr_en = psel && penable && pwrite;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a0    <= '0;
            a1    <= '0;
            b0    <= '0;
            b1    <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    apb_regs_pkg::REG_A0: begin
                        a0 <= pwdata[M-1:0];
                    end
                    apb_regs_pkg::REG_B0: begin
                        b0 <= pwdata[N-1:0];
                    end
                    apb_regs_pkg::REG_A1: begin
                        a1 <= pwdata[M-1:0];
                    end
                    apb_regs_pkg::REG_B1: begin
                        b1 <= pwdata[N-1:0];
                    end
                    apb_regs_pkg::REG_CTRL: begin
                        // A start request during a run is simply lost.
                        start <= pwdata[apb_regs_pkg::CTRL_START_BIT] && !busy;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            apb_regs_pkg::REG_A0: begin
                prdata[M-1:0] = a0;
            end
            apb_regs_pkg::REG_B0: begin
                prdata[N-1:0] = b0;
            end
            apb_regs_pkg::REG_A1: begin
                prdata[M-1:0] = a1;
            end
            apb_regs_pkg::REG_B1: begin
                prdata[N-1:0] = b1;
            end
            apb_regs_pkg::REG_STATUS: begin
                prdata[apb_regs_pkg::STAT_BUSY_BIT] = busy;
                prdata[apb_regs_pkg::STAT_DONE_BIT] = done;
            end
            apb_regs_pkg::REG_RESULT: begin
                prdata[M+N:0] = sum;
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

// ==== verilog/apb_regs_pkg.sv ====
package apb_regs_pkg;

    localparam int ADDR_W = 8;

    // Word offsets of the peripheral registers.
    localparam logic [ADDR_W-1:0] REG_A0     = 8'h00;
    localparam logic [ADDR_W-1:0] REG_B0     = 8'h04;
    localparam logic [ADDR_W-1:0] REG_A1     = 8'h08;
    localparam logic [ADDR_W-1:0] REG_B1     = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h10;
    localparam logic [ADDR_W-1:0] REG_STATUS = 8'h14;
    localparam logic [ADDR_W-1:0] REG_RESULT = 8'h18;

    // Bit positions inside CTRL and STATUS.
    localparam int CTRL_START_BIT = 0;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage

// ==== verilog/dot2_mul_top.sv ====
`timescale 1ns/1ps

module dot2_mul_top #(
    parameter int M = mul_pkg::OP_W_DEFAULT,
    parameter int N = mul_pkg::OP_W_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [apb_regs_pkg::ADDR_W-1:0] paddr,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready
);

    logic [M-1:0]   a0;
    logic [M-1:0]   a1;
    logic [N-1:0]   b0;
    logic [N-1:0]   b1;
    logic           start;
    logic           busy;
    logic           done;
    logic [M+N:0]   sum;
    logic [M+N-1:0] product0;
    logic [M+N-1:0] product1;
    logic           lane_done0;
    logic           lane_done1;

    apb_dot_regs #(
        .M(M),
        .N(N)
    ) u_regs (
        .clk    (clk),
        .rst    (rst),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .busy   (busy),
        .done   (done),
        .sum    (sum),
        .prdata (prdata),
        .pready (pready),
        .a0     (a0),
        .a1     (a1),
        .b0     (b0),
        .b1     (b1),
        .start  (start)
    );

    shift_add_lane #(
        .M(M),
        .N(N)
    ) lane0 (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .multiplicand(a0),
        .multiplier  (b0),
        .product     (product0),
        .lane_done   (lane_done0)
    );

    shift_add_lane #(
        .M(M),
        .N(N)
    ) lane1 (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .multiplicand(a1),
        .multiplier  (b1),
        .product     (product1),
        .lane_done   (lane_done1)
    );

    dot_combiner #(
        .W(M + N)
    ) u_combiner (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .done0   (lane_done0),
        .done1   (lane_done1),
        .product0(product0),
        .product1(product1),
        .sum     (sum),
        .busy    (busy),
        .done    (done)
    );

endmodule

// ==== verilog/dot_combiner.sv ====
`timescale 1ns/1ps

module dot_combiner #(
    parameter int W = 16
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         done0,
    input  logic         done1,
    input  logic [W-1:0] product0,
    input  logic [W-1:0] product1,
    output logic [W:0]   sum,
    output logic         busy,
    output logic         done
);

    logic       seen0;
    logic       seen1;
    logic [W:0] pair_sum;

    assign pair_sum = {1'b0, product0} + {1'b0, product1};

    // Lanes may finish in either order or together, so each one is latched.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen0 <= 1'b0;
            seen1 <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
            sum   <= '0;
        end else if (start) begin
            seen0 <= 1'b0;
            seen1 <= 1'b0;
            busy  <= 1'b1;
            done  <= 1'b0;
        end else if (busy && seen0 && seen1) begin
            sum   <= pair_sum;
            busy  <= 1'b0;
            done  <= 1'b1;
            seen0 <= 1'b0;
            seen1 <= 1'b0;
        end else begin
            if (done0)
                seen0 <= 1'b1;
            if (done1)
                seen1 <= 1'b1;
        end
    end

endmodule

// ==== verilog/mul_pkg.sv ====
package mul_pkg;

    // Operand width used when the top level is not overridden.
    localparam int OP_W_DEFAULT = 8;

    // Lane controller states.
    // TEST looks at the multiplier LSB, ADD folds in the multiplicand and
    // SHIFT moves the accumulator and multiplier right by one bit.
    typedef enum logic [2:0] {
        IDLE  = 3'b000,
        LOAD  = 3'b001,
        TEST  = 3'b010,
        ADD   = 3'b011,
        SHIFT = 3'b100
    } ctrl_state_t;

endpackage

// ==== verilog/shift_add_ctrl.sv ====
`timescale 1ns/1ps

module shift_add_ctrl #(
    parameter int N = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic lsb,
    output logic load_cmd,
    output logic add_cmd,
    output logic shift_cmd,
    output logic lane_done
);

    localparam int CNT_W = $clog2(N + 1);

    mul_pkg::ctrl_state_t state;
    mul_pkg::ctrl_state_t state_next;
    logic [CNT_W-1:0]     bit_cnt;
    logic                 last_bit;

    // The shift in progress is the last one once N-1 shifts are already done.
    assign last_bit = (bit_cnt == CNT_W'(N - 1));

    always_comb begin
        state_next = state;
        case (state)
            mul_pkg::IDLE: begin
                if (start)
                    state_next = mul_pkg::LOAD;
            end
            mul_pkg::LOAD: begin
                state_next = mul_pkg::TEST;
            end
            mul_pkg::TEST: begin
                if (lsb)
                    state_next = mul_pkg::ADD;
                else
                    state_next = mul_pkg::SHIFT;
            end
            mul_pkg::ADD: begin
                state_next = mul_pkg::SHIFT;
            end
            mul_pkg::SHIFT: begin
                if (last_bit)
                    state_next = mul_pkg::IDLE;
                else
                    state_next = mul_pkg::TEST;
            end
            default: begin
                state_next = mul_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= mul_pkg::IDLE;
            bit_cnt   <= '0;
            lane_done <= 1'b0;
        end else begin
            state     <= state_next;
            // Pulses in the first IDLE cycle, when the product register is final.
            lane_done <= (state == mul_pkg::SHIFT) && last_bit;
            if (state == mul_pkg::LOAD)
                bit_cnt <= '0;
            else if (state == mul_pkg::SHIFT)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign load_cmd  = (state == mul_pkg::LOAD);
    assign add_cmd   = (state == mul_pkg::ADD);
    assign shift_cmd = (state == mul_pkg::SHIFT);

endmodule

// ==== verilog/shift_add_lane.sv ====
`timescale 1ns/1ps

module shift_add_lane #(
    parameter int M = 8,
    parameter int N = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic [M-1:0] multiplicand,
    input  logic [N-1:0] multiplier,
    output logic [M+N-1:0] product,
    output logic         lane_done
);

    logic [M-1:0] mcand_q;
    logic [N-1:0] mplier_q;
    // Layout is {carry, accumulator[M-1:0], multiplier[N-1:0]}.
    logic [M+N:0] acc_q;
    logic [M:0]   add_sum;
    logic         load_cmd;
    logic         add_cmd;
    logic         shift_cmd;

    // Operands are taken at start so software may rewrite them mid-run.
    always_ff @(posedge clk) begin
        if (start) begin
            mcand_q  <= multiplicand;
            mplier_q <= multiplier;
        end
    end

    assign add_sum = {1'b0, acc_q[M+N-1:N]} + {1'b0, mcand_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_q <= '0;
        end else if (load_cmd) begin
            acc_q <= {{(M + 1){1'b0}}, mplier_q};
        end else if (add_cmd) begin
            acc_q[M+N:N] <= add_sum;
        end else if (shift_cmd) begin
            // The carry drops into the accumulator MSB here.
            acc_q <= {1'b0, acc_q[M+N:1]};
        end
    end

    assign product = acc_q[M+N-1:0];

    shift_add_ctrl #(
        .N(N)
    ) u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .lsb      (acc_q[0]),
        .load_cmd (load_cmd),
        .add_cmd  (add_cmd),
        .shift_cmd(shift_cmd),
        .lane_done(lane_done)
    );

endmodule
